// ==== fetch_pkg.sv ====
package fetch_pkg;

    localparam logic [31:0] reset_pc   = 32'hbfc0_0000;
    localparam logic [31:0] exc_vector = 32'hbfc0_0380;

    localparam logic [4:0] exc_adel = 5'd4; // address error on instruction fetch.

    localparam int btb_entries   = 8;
    localparam int icache_lines  = 8;
    localparam int rom_words     = 256;
    localparam int refill_cycles = 4; // cycles that a miss holds busy high.

    // pre-fetch to fetch bundle, 39 bits.
    typedef struct packed {
        logic        inst_valid;
        logic [31:0] pc;
        logic        ex;
        logic [4:0]  exctype;
    } ps_to_fs_t;

    // fetch to decode bundle, 71 bits.
    typedef struct packed {
        logic        ex;
        logic [4:0]  exctype;
        logic        bd;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic [31:0] target;
        logic        predict_valid;
    } bpu_to_ps_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } bpu_to_ds_t;

    // branch resolution coming back from decode, 67 bits.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        is_branch;
        logic        taken;
        logic [31:0] target;
    } branch_result_t;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } icache_req_t;

endpackage

// ==== branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ds_allowin,
    input  logic [31:0]               fs_pc,
    input  fetch_pkg::branch_result_t branch_result,
    output logic [31:0]               target,
    output logic                      bpu_valid,
    output fetch_pkg::bpu_to_ds_t     bpu_to_ds_bus
);
    import fetch_pkg::*;

    localparam int idx_w = $clog2(btb_entries);
    localparam int tag_w = 30 - idx_w;

    logic [btb_entries-1:0] btb_valid;
    logic [tag_w-1:0]       btb_tag    [btb_entries];
    logic [31:0]            btb_target [btb_entries];
    logic [1:0]             btb_ctr    [btb_entries];

    logic [idx_w-1:0] rd_idx;
    logic             rd_hit;
    logic [idx_w-1:0] wr_idx;
    logic [tag_w-1:0] wr_tag;
    logic             wr_hit;
    logic             update;

    assign rd_idx    = fs_pc[idx_w+1:2];
    assign rd_hit    = btb_valid[rd_idx] && (btb_tag[rd_idx] == fs_pc[31:idx_w+2]);
    assign bpu_valid = rd_hit & btb_ctr[rd_idx][1]; // taken when the counter is 2 or 3.
    assign target    = btb_target[rd_idx];

    assign bpu_to_ds_bus = '{taken: bpu_valid, target: btb_target[rd_idx]};

    // a resolution counts once, when decode passes the branch on.
    assign update = branch_result.valid & branch_result.is_branch & ds_allowin;
    assign wr_idx = branch_result.pc[idx_w+1:2];
    assign wr_tag = branch_result.pc[31:idx_w+2];
    assign wr_hit = btb_valid[wr_idx] && (btb_tag[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (update && !wr_hit && branch_result.taken) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            if (wr_hit) begin
                if (branch_result.taken) begin
                    btb_target[wr_idx] <= branch_result.target;
                    if (btb_ctr[wr_idx] != 2'b11) begin
                        btb_ctr[wr_idx] <= btb_ctr[wr_idx] + 2'd1;
                    end
                end else if (btb_ctr[wr_idx] != 2'b00) begin
                    btb_ctr[wr_idx] <= btb_ctr[wr_idx] - 2'd1;
                end
            end else if (branch_result.taken) begin
                btb_tag[wr_idx]    <= wr_tag; // replaces whatever sat at this index.
                btb_target[wr_idx] <= branch_result.target;
                btb_ctr[wr_idx]    <= 2'b10;
            end
        end
    end

endmodule

// ==== inst_cache.sv ====
`timescale 1ns/1ps

module inst_cache (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  fetch_pkg::icache_req_t icache_req,
    output logic                   icache_busy,
    output logic [31:0]            inst_rdata
);
    import fetch_pkg::*;

    localparam int line_w = $clog2(icache_lines);
    localparam int tag_w  = 30 - line_w;
    localparam int rom_w  = $clog2(rom_words);
    localparam int cnt_w  = $clog2(refill_cycles + 1);

    logic [31:0] rom [rom_words];

    logic [31:0]             line_data [icache_lines];
    logic [tag_w-1:0]        line_tag  [icache_lines];
    logic [icache_lines-1:0] line_valid;

    logic              lookup;
    logic [31:0]       lookup_addr;
    logic [line_w-1:0] lookup_idx;
    logic [tag_w-1:0]  lookup_tag;
    logic              hit;
    logic              start_refill;
    logic              refilling;
    logic              refill_done;
    logic [cnt_w-1:0]  refill_cnt;
    logic [line_w-1:0] refill_idx;
    logic [tag_w-1:0]  refill_tag;
    logic [31:0]       refill_word;

    initial begin
        $readmemh("inst_mem.hex", rom);
    end

    assign lookup_idx   = lookup_addr[line_w+1:2];
    assign lookup_tag   = lookup_addr[31:line_w+2];
    assign hit          = line_valid[lookup_idx] && (line_tag[lookup_idx] == lookup_tag);
    assign start_refill = lookup & ~hit & ~refilling & ~flush;
    assign refill_done  = refilling && (refill_cnt == cnt_w'(1));
    assign icache_busy  = refilling | (lookup & ~hit);
    assign inst_rdata   = line_data[lookup_idx]; // the held address keeps the word stable.

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup     <= 1'b0;
            refilling  <= 1'b0;
            refill_cnt <= '0;
            line_valid <= '0;
        end else begin
            if (flush) begin
                lookup <= 1'b0; // drops a lookup whose refill has not begun.
            end else if (icache_req.req) begin
                lookup <= 1'b1;
            end
            if (start_refill) begin
                refilling  <= 1'b1;
                refill_cnt <= cnt_w'(refill_cycles - 1);
            end else if (refilling) begin
                refill_cnt <= refill_cnt - cnt_w'(1);
                if (refill_done) begin
                    refilling              <= 1'b0;
                    line_valid[refill_idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req.req) begin
            lookup_addr <= icache_req.addr;
        end
        if (start_refill) begin
            refill_idx  <= lookup_idx;
            refill_tag  <= lookup_tag;
            refill_word <= rom[lookup_addr[rom_w+1:2]];
        end
        if (refill_done) begin
            line_data[refill_idx] <= refill_word;
            line_tag[refill_idx]  <= refill_tag;
        end
    end

endmodule

// ==== pre_if_stage.sv ====
`timescale 1ns/1ps

module pre_if_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fs_allowin,
    input  logic                      br_flush,
    input  logic                      flush,
    input  fetch_pkg::branch_result_t branch_result,
    input  fetch_pkg::bpu_to_ps_t     bpu_to_ps_bus,
    output logic                      ps_to_fs_valid,
    output fetch_pkg::ps_to_fs_t      ps_to_fs_bus,
    output fetch_pkg::icache_req_t    icache_req
);
    import fetch_pkg::*;

    logic        run;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        exc_pending;
    logic        redir_valid;
    logic [31:0] redir_pc;
    logic        aligned;

    always_comb begin
        if (exc_pending) begin
            next_pc = exc_vector;
        end else if (br_flush) begin
            next_pc = branch_result.target;
        end else if (redir_valid) begin
            next_pc = redir_pc; // held branch target or predicted target.
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    assign aligned        = (next_pc[1:0] == 2'b00);
    assign ps_to_fs_valid = run & fs_allowin & ~flush; // nothing is issued in a flush cycle.
    assign icache_req     = '{req: ps_to_fs_valid & aligned, addr: next_pc};
    assign ps_to_fs_bus   = '{
        inst_valid: aligned,
        pc:         next_pc,
        ex:         ~aligned,
        exctype:    aligned ? 5'd0 : exc_adel
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
            pc  <= reset_pc - 32'd4; // so that the first issue is reset_pc.
        end else begin
            run <= 1'b1;
            if (ps_to_fs_valid) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_pending <= 1'b0;
        end else if (flush) begin
            exc_pending <= 1'b1;
        end else if (ps_to_fs_valid) begin
            exc_pending <= 1'b0;
        end
    end

    // a prediction is seen while the delay slot is issued, so the target goes out next.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            redir_valid <= 1'b0;
        end else if (br_flush && !exc_pending && !ps_to_fs_valid) begin
            redir_valid <= 1'b1;
        end else if (ps_to_fs_valid) begin
            redir_valid <= bpu_to_ps_bus.predict_valid & ~exc_pending & ~br_flush & ~redir_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (br_flush && !ps_to_fs_valid) begin
            redir_pc <= branch_result.target;
        end else if (ps_to_fs_valid && bpu_to_ps_bus.predict_valid) begin
            redir_pc <= bpu_to_ps_bus.target;
        end
    end

endmodule

// ==== if_stage.sv ====
`timescale 1ns/1ps

module if_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ds_allowin,
    input  logic                      ps_to_fs_valid,
    input  logic                      fs_bd,
    input  logic                      br_flush,
    input  logic                      flush,
    input  logic                      icache_busy,
    input  fetch_pkg::ps_to_fs_t      ps_to_fs_bus,
    input  fetch_pkg::branch_result_t branch_result,
    input  logic [31:0]               inst_rdata,
    output logic                      fs_allowin,
    output logic                      fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t      fs_to_ds_bus,
    output fetch_pkg::bpu_to_ps_t     bpu_to_ps_bus,
    output fetch_pkg::bpu_to_ds_t     bpu_to_ds_bus
);
    import fetch_pkg::*;

    logic        fs_valid;
    logic        fs_ready_go;
    ps_to_fs_t   fs_bus_r;
    logic [31:0] bpu_target;
    logic        bpu_valid;

    assign fs_ready_go    = ~icache_busy; // the word is ready once the cache is idle.
    assign fs_allowin     = ~fs_valid | (fs_ready_go & ds_allowin);
    assign fs_to_ds_valid = fs_valid & fs_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= ps_to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_bus_r <= '0;
        end else if (ps_to_fs_valid && fs_allowin) begin
            fs_bus_r <= ps_to_fs_bus;
        end
    end

    // on br_flush the slot becomes a nop that carries the branch's own pc.
    assign fs_to_ds_bus = '{
        ex:      fs_bus_r.ex,
        exctype: fs_bus_r.exctype,
        bd:      fs_bd,
        inst:    (br_flush || !fs_bus_r.inst_valid) ? 32'd0 : inst_rdata,
        pc:      br_flush ? fs_bus_r.pc - 32'd8 : fs_bus_r.pc
    };

    assign bpu_to_ps_bus = '{
        target:        bpu_target,
        predict_valid: bpu_valid & fs_valid & ~br_flush & fs_bus_r.inst_valid
    };

    branch_predictor branch_predictor_i (
        .clk           (clk),
        .reset         (reset),
        .ds_allowin    (ds_allowin),
        .fs_pc         (fs_bus_r.pc),
        .branch_result (branch_result),
        .target        (bpu_target),
        .bpu_valid     (bpu_valid),
        .bpu_to_ds_bus (bpu_to_ds_bus)
    );

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ds_allowin,
    input  logic                      fs_bd,
    input  logic                      br_flush,
    input  logic                      flush,
    input  fetch_pkg::branch_result_t branch_result,
    output logic                      fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t      fs_to_ds_bus,
    output fetch_pkg::bpu_to_ds_t     bpu_to_ds_bus
);
    import fetch_pkg::*;

    logic        fs_allowin;
    logic        ps_to_fs_valid;
    ps_to_fs_t   ps_to_fs_bus;
    bpu_to_ps_t  bpu_to_ps_bus;
    icache_req_t icache_req;
    logic        icache_busy;
    logic [31:0] inst_rdata;

    pre_if_stage pre_if_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_allowin     (fs_allowin),
        .br_flush       (br_flush),
        .flush          (flush),
        .branch_result  (branch_result),
        .bpu_to_ps_bus  (bpu_to_ps_bus),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_to_fs_bus   (ps_to_fs_bus),
        .icache_req     (icache_req)
    );

    if_stage if_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .ps_to_fs_valid (ps_to_fs_valid),
        .fs_bd          (fs_bd),
        .br_flush       (br_flush),
        .flush          (flush),
        .icache_busy    (icache_busy),
        .ps_to_fs_bus   (ps_to_fs_bus),
        .branch_result  (branch_result),
        .inst_rdata     (inst_rdata),
        .fs_allowin     (fs_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .bpu_to_ps_bus  (bpu_to_ps_bus),
        .bpu_to_ds_bus  (bpu_to_ds_bus)
    );

    inst_cache inst_cache_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .icache_req  (icache_req),
        .icache_busy (icache_busy),
        .inst_rdata  (inst_rdata)
    );

endmodule

// ==== fetch_assertions.sv ====
`timescale 1ns/1ps

module fetch_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  ds_allowin,
    input logic                  br_flush,
    input logic                  flush,
    input logic                  icache_busy,
    input logic                  fs_to_ds_valid,
    input fetch_pkg::fs_to_ds_t  fs_to_ds_bus,
    input fetch_pkg::bpu_to_ps_t bpu_to_ps_bus
);
    import fetch_pkg::*;

    int fail_count = 0;

    // a stalled bundle may only change when a redirect rewrites it.
    bundle_stable: assert property (@(posedge clk) disable iff (reset)
        (fs_to_ds_valid && !ds_allowin && !br_flush && !flush) |=> (br_flush || $stable(fs_to_ds_bus)))
        else begin
            fail_count = fail_count + 1;
            $error("fs_to_ds_bus changed while decode was stalled");
        end

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!fs_to_ds_valid && !bpu_to_ps_bus.predict_valid && !icache_busy))
        else begin
            fail_count = fail_count + 1;
            $error("control outputs not idle after reset");
        end

    busy_bounded: assert property (@(posedge clk) disable iff (reset)
        icache_busy [*refill_cycles] |=> !icache_busy)
        else begin
            fail_count = fail_count + 1;
            $error("icache_busy held longer than one refill");
        end

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;
    import fetch_pkg::*;

    localparam logic [31:0] branch_pc  = reset_pc + 32'h10;
    localparam logic [31:0] loop_last  = reset_pc + 32'h18;
    localparam logic [31:0] bad_target = exc_vector + 32'h22;
    localparam int timeout_cycles = 200;

    logic           clk;
    logic           reset;
    logic           ds_allowin;
    logic           fs_bd;
    logic           br_flush;
    logic           flush;
    branch_result_t branch_result;
    logic           fs_to_ds_valid;
    fs_to_ds_t      fs_to_ds_bus;
    bpu_to_ds_t     bpu_to_ds_bus;

    logic [31:0]    rom_model [rom_words];
    integer         seed;
    int             value_errors;
    int             busy_run;
    logic [31:0]    exp_pc;
    logic           trained;
    logic           delay_slot_next;
    branch_result_t train_res;
    branch_result_t bad_res;

    fetch_top fetch_top_i (.*);

    bind if_stage fetch_assertions fetch_assertions_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_cycle();
        logic [31:0] want_inst;
        logic        misaligned;
        logic        want_bd;
        if (fetch_top_i.icache_busy) begin
            busy_run++;
            // every loop line is cached once the branch has trained.
            assert (!(trained && exp_pc < exc_vector)) else begin
                value_errors++;
                $display("cache missed at pc %h on a later pass through the loop", exp_pc);
            end
        end else begin
            if (busy_run != 0) compare("icache_busy cycles", refill_cycles, busy_run);
            busy_run = 0;
        end
        if (fs_to_ds_valid && ds_allowin && !flush) begin
            if (br_flush) begin
                compare("fs_to_ds_bus.pc", exp_pc - 32'd8, fs_to_ds_bus.pc);
                compare("fs_to_ds_bus.inst", 32'd0, fs_to_ds_bus.inst);
                exp_pc = branch_result.target;
                delay_slot_next = 1'b0;
            end else begin
                misaligned = (exp_pc[1:0] != 2'b00);
                want_inst  = misaligned ? 32'd0 : rom_model[exp_pc[9:2]];
                want_bd    = (exp_pc == branch_pc + 32'd4);
                compare("fs_to_ds_bus.pc", exp_pc, fs_to_ds_bus.pc);
                compare("fs_to_ds_bus.inst", want_inst, fs_to_ds_bus.inst);
                compare("fs_to_ds_bus.ex", {31'd0, misaligned}, {31'd0, fs_to_ds_bus.ex});
                compare("fs_to_ds_bus.exctype", misaligned ? exc_adel : 32'd0,
                        {27'd0, fs_to_ds_bus.exctype});
                compare("fs_to_ds_bus.bd", {31'd0, want_bd}, {31'd0, fs_to_ds_bus.bd});
                if (trained && exp_pc == branch_pc) begin
                    compare("bpu_to_ds_bus.taken", 32'd1, {31'd0, bpu_to_ds_bus.taken});
                    compare("bpu_to_ds_bus.target", reset_pc, bpu_to_ds_bus.target);
                end else begin
                    compare("bpu_to_ds_bus.taken", 32'd0, {31'd0, bpu_to_ds_bus.taken});
                end
                if (delay_slot_next) begin
                    exp_pc = reset_pc; // the predicted target follows the delay slot.
                    delay_slot_next = 1'b0;
                end else begin
                    delay_slot_next = trained && (exp_pc == branch_pc);
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
        if (flush) begin
            exp_pc = exc_vector;
            delay_slot_next = 1'b0;
        end
    endtask

    // called on a falling edge and returns on the next one.
    task automatic drive_cycle(input logic force_go, input logic do_br, input logic do_flush,
                               input branch_result_t res);
        ds_allowin    = force_go ? 1'b1 : (($random(seed) & 3) != 0);
        fs_bd         = (exp_pc == branch_pc + 32'd4); // decode holds the loop branch.
        br_flush      = do_br;
        flush         = do_flush;
        branch_result = res;
        #1;
        check_cycle();
        @(negedge clk);
    endtask

    task automatic run_until(input logic [31:0] pc_want);
        int n;
        n = 0;
        while (!(fs_to_ds_valid &&
                 fs_to_ds_bus.pc == (br_flush ? pc_want - 32'd8 : pc_want))) begin
            if (n == timeout_cycles) begin
                $display("timeout while waiting for pc %h in the fetch stage", pc_want);
                $display("Simulation failed");
                $finish;
            end
            drive_cycle(1'b0, 1'b0, 1'b0, '0);
            n++;
        end
    endtask

    initial begin
        seed            = 32'h569b_20de;
        value_errors    = 0;
        busy_run        = 0;
        exp_pc          = reset_pc;
        trained         = 1'b0;
        delay_slot_next = 1'b0;
        reset           = 1'b1;
        ds_allowin      = 1'b0;
        fs_bd           = 1'b0;
        br_flush        = 1'b0;
        flush           = 1'b0;
        branch_result   = '0;
        train_res = '{valid: 1'b1, pc: branch_pc, is_branch: 1'b1, taken: 1'b1,
                      target: reset_pc};
        bad_res   = '{valid: 1'b0, pc: '0, is_branch: 1'b0, taken: 1'b0, target: bad_target};
        $readmemh("inst_mem.hex", rom_model);
        repeat (3) @(negedge clk);
        reset = 1'b0;
        #1;
        compare("fs_to_ds_valid", 32'd0, {31'd0, fs_to_ds_valid});
        @(negedge clk);
        // the first pass misses and then decode resolves the loop branch.
        run_until(loop_last);
        drive_cycle(1'b1, 1'b1, 1'b0, train_res);
        trained = 1'b1;
        // second pass hits and follows the prediction.
        run_until(branch_pc);
        run_until(branch_pc + 32'd4);
        run_until(reset_pc);
        drive_cycle(1'b1, 1'b0, 1'b1, '0);
        run_until(exc_vector + 32'd8);
        drive_cycle(1'b1, 1'b1, 1'b0, bad_res);
        repeat (10) drive_cycle(1'b0, 1'b0, 1'b0, '0);
        $display("errors: value %0d, assertion %0d", value_errors,
                 fetch_top_i.if_stage_i.fetch_assertions_i.fail_count);
        if (value_errors == 0 && fetch_top_i.if_stage_i.fetch_assertions_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== inst_mem.hex ====
// instruction rom, one 32-bit word per line in hex, word 0 sits at reset_pc.
// a short loop with its branch at word 4, the exception handler starts at word e0.
24020000
24420001
24630004
2484ffff
1000fffb
24420002
00000000
24a50008
8c460000
ac460004
00000000
3c08bfc0
35080380
01000008
00000000
24020010
24030020
@e0
401a6800
335a007c
00000000
42000018

// ==== filelist.f ====
fetch_pkg.sv
branch_predictor.sv
inst_cache.sv
pre_if_stage.sv
if_stage.sv
fetch_top.sv
fetch_assertions.sv
tb_fetch.sv
